//--- common/ooo_pkg.sv
package ooo_pkg;

    // datapath widths.
    parameter int DATA_W = 32;
    parameter int TAG_W  = 6;
    parameter int PC_W   = 32;

    // rv32i major opcodes seen at dispatch.
    parameter logic [6:0] OPC_RTYPE = 7'b0110011;
    parameter logic [6:0] OPC_ITYPE = 7'b0010011;
    parameter logic [6:0] OPC_LUI   = 7'b0110111;
    parameter logic [6:0] OPC_LOAD  = 7'b0000011;
    parameter logic [6:0] OPC_STORE = 7'b0100011;

    // funct3 values that select an operation.
    parameter logic [2:0] F3_ADD  = 3'b000;
    parameter logic [2:0] F3_XOR  = 3'b100;
    parameter logic [2:0] F3_SRAI = 3'b101;
    parameter logic [2:0] F3_ORI  = 3'b110;

    // operations the ALUs execute; OP_NONE means drop at dispatch.
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_ADD  = 4'd1,
        OP_XOR  = 4'd2,
        OP_ADDI = 4'd3,
        OP_ORI  = 4'd4,
        OP_SRAI = 4'd5,
        OP_LUI  = 4'd6
    } op_type_t;

endpackage

//--- dv/cdb_checker.sv
`timescale 1ns/1ns

module cdb_checker #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        queue_full,
    input  logic                        cdb_valid,
    input  logic [ooo_pkg::TAG_W-1:0]   cdb_tag,
    input  logic [ooo_pkg::DATA_W-1:0]  cdb_data
);

    localparam int NUM_TAGS = 1 << ooo_pkg::TAG_W;

    logic                       exp_valid [NUM_TAGS];
    logic [ooo_pkg::DATA_W-1:0] exp_data  [NUM_TAGS];
    logic                       seen      [NUM_TAGS];
    logic [ooo_pkg::DATA_W-1:0] seen_data [NUM_TAGS];

    int   value_errors;
    int   bcast_errors;
    int   missing_errors;
    int   fill_errors;
    int   seen_count;
    int   accepted;
    logic full_seen;

    initial begin
        value_errors   = 0;
        bcast_errors   = 0;
        missing_errors = 0;
        fill_errors    = 0;
        seen_count     = 0;
        accepted       = 0;
        full_seen      = 1'b0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            exp_valid[t] = 1'b0;
            seen[t]      = 1'b0;
        end
    end

    task automatic add_expected(input logic [ooo_pkg::TAG_W-1:0] tag,
                                input logic [ooo_pkg::DATA_W-1:0] value);
        if (exp_valid[tag]) begin
            $display("tag %0d is listed twice as a result in the stimulus file", tag);
            bcast_errors++;
        end
        exp_valid[tag] = 1'b1;
        exp_data[tag]  = value;
    endtask

    // one more instruction enters the queue at the next rising edge.
    task automatic note_dispatch();
        accepted++;
    endtask

    // the bus is valid for one cycle, stable at the falling edge.
    always @(negedge clk) begin
        if (rstn && cdb_valid) begin
            if (!exp_valid[cdb_tag]) begin
                $display("tag %0d was broadcast at %0t but no result was expected",
                         cdb_tag, $time);
                bcast_errors++;
            end else if (seen[cdb_tag]) begin
                $display("tag %0d was broadcast a second time at %0t", cdb_tag, $time);
                bcast_errors++;
            end else begin
                seen_count++;
                if (cdb_data !== exp_data[cdb_tag]) begin
                    $display("Error: time %0t, tag %0d, expected %h, got %h",
                             $time, cdb_tag, exp_data[cdb_tag], cdb_data);
                    value_errors++;
                end
            end
            seen[cdb_tag]      = 1'b1;
            seen_data[cdb_tag] = cdb_data;
        end
        // a full queue holds that many instructions that have not broadcast yet.
        if (rstn && queue_full) begin
            full_seen = 1'b1;
            if (accepted - seen_count < QUEUE_DEPTH) begin
                $display("Error: time %0t, queue_full high with %0d instructions outstanding",
                         $time, accepted - seen_count);
                fill_errors++;
            end
        end
    end

    task automatic report_missing();
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (exp_valid[t] && !seen[t]) begin
                $display("tag %0d was expected but never broadcast", t);
                missing_errors++;
            end
        end
    endtask

    task automatic check_queue_filled();
        if (!full_seen) begin
            $display("queue_full never rose, so dispatch was never held back");
            fill_errors++;
        end
    endtask

endmodule

//--- dv/ooo_stimulus.txt
// pc opcode funct3 src1_tag src1_rdy src1_data src2_tag src2_rdy src2_data
// imm dest_tag expected_result broadcast_expected (all hex)
00000000 33 0 00 1 00000011 00 1 00000022 deadbeef 01 00000033 1
00000004 33 4 00 1 f0f0f0f0 00 1 0ff00ff0 00000000 02 ff00ff00 1
00000008 13 0 00 1 00001000 3f 0 12345678 fffffff0 03 00000ff0 1
0000000c 13 6 00 1 12340000 00 1 aaaaaaaa 000000ff 04 123400ff 1
00000010 13 5 00 1 80000000 00 1 55555555 00000404 05 f8000000 1
00000014 37 0 3e 0 cafef00d 3d 0 0badf00d abcde000 06 abcde000 1
00000018 33 0 01 0 00000000 02 0 00000000 00000000 07 ff00ff33 1
0000001c 13 0 07 0 00000000 3f 0 00000000 00000001 08 ff00ff34 1
00000020 33 4 08 0 00000000 06 0 00000000 00000000 09 54cd1f34 1
00000024 13 5 09 0 00000000 3f 0 00000000 00000008 0a 0054cd1f 1
00000028 03 2 01 1 00000100 00 1 00000000 00000004 0b 00000000 0
0000002c 23 2 01 1 00000100 02 1 00000000 00000008 0c 00000000 0
00000030 7f 0 00 1 00000000 00 1 00000000 00000000 0d 00000000 0
00000034 33 1 00 1 00000001 00 1 00000002 00000000 0f 00000000 0
00000038 13 6 0a 0 00000000 3f 0 00000000 0f000000 0e 0f54cd1f 1
0000003c 37 0 3e 0 00000000 3d 0 00000000 00010000 10 00010000 1
00000040 13 0 10 0 00000000 3f 0 00000000 00000010 11 00010010 1
00000044 13 0 11 0 00000000 3f 0 00000000 00000020 12 00010030 1
00000048 33 0 12 0 00000000 00 1 00000001 00000000 13 00010031 1
0000004c 33 4 12 0 00000000 00 1 0000ffff 00000000 14 0001ffcf 1
00000050 13 0 12 0 00000000 3f 0 00000000 ffffffff 15 0001002f 1
00000054 13 6 12 0 00000000 3f 0 00000000 00000f00 16 00010f30 1
00000058 13 5 12 0 00000000 3f 0 00000000 00000004 17 00001003 1
0000005c 33 0 12 0 00000000 12 0 00000000 00000000 18 00020060 1
00000060 33 0 00 1 00000100 12 0 00000000 00000000 19 00010130 1
00000064 33 0 00 1 00000001 00 1 00000002 00000000 20 00000003 1
00000068 13 0 00 1 00000005 00 1 00000000 00000005 21 0000000a 1
0000006c 33 4 00 1 0000ffff 00 1 ffffffff 00000000 22 ffff0000 1
00000070 13 6 00 1 00000001 00 1 00000000 00000100 23 00000101 1
00000074 37 0 3e 0 00000000 3d 0 00000000 7ffff000 24 7ffff000 1
00000078 13 5 00 1 7fffffff 00 1 00000000 0000001f 25 00000000 1
0000007c 33 0 00 1 ffffffff 00 1 00000001 00000000 26 00000000 1

//--- dv/tb_top.sv
`timescale 1ns/1ns

module tb_top;

    localparam int QUEUE_DEPTH = 8;
    localparam int NUM_ALUS    = 3;
    // words per stimulus line.
    localparam int REC_W       = 13;
    localparam int MAX_LINES   = 64;

    logic                        clk;
    logic                        rstn;
    logic                        dispatch_valid;
    logic [ooo_pkg::PC_W-1:0]    pc;
    logic [6:0]                  opcode;
    logic [2:0]                  funct3;
    logic [ooo_pkg::TAG_W-1:0]   src1_tag;
    logic                        src1_ready;
    logic [ooo_pkg::DATA_W-1:0]  src1_data;
    logic [ooo_pkg::TAG_W-1:0]   src2_tag;
    logic                        src2_ready;
    logic [ooo_pkg::DATA_W-1:0]  src2_data;
    logic [ooo_pkg::DATA_W-1:0]  imm;
    logic [ooo_pkg::TAG_W-1:0]   dest_tag;
    logic                        queue_full;
    logic                        cdb_valid;
    logic [ooo_pkg::TAG_W-1:0]   cdb_tag;
    logic [ooo_pkg::DATA_W-1:0]  cdb_data;

    logic [31:0] stim [REC_W*MAX_LINES];
    int          num_lines;
    int          num_expected;
    int          setup_errors;
    int          cycle_count;
    int          cycle_limit = 100;

    ooo_core_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .NUM_ALUS    (NUM_ALUS)
    ) dut (
        .clk            (clk),
        .rstn           (rstn),
        .dispatch_valid (dispatch_valid),
        .pc             (pc),
        .opcode         (opcode),
        .funct3         (funct3),
        .src1_tag       (src1_tag),
        .src1_ready     (src1_ready),
        .src1_data      (src1_data),
        .src2_tag       (src2_tag),
        .src2_ready     (src2_ready),
        .src2_data      (src2_data),
        .imm            (imm),
        .dest_tag       (dest_tag),
        .queue_full     (queue_full),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data)
    );

    cdb_checker #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_checker (
        .clk        (clk),
        .rstn       (rstn),
        .queue_full (queue_full),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_data   (cdb_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // source state as a renamer sees it at dispatch time.
    task automatic drive_source(input logic [ooo_pkg::TAG_W-1:0] tag,
                                input logic rdy_in,
                                input logic [ooo_pkg::DATA_W-1:0] data_in,
                                output logic rdy_out,
                                output logic [ooo_pkg::DATA_W-1:0] data_out);
        if (rdy_in) begin
            rdy_out  = 1'b1;
            data_out = data_in;
        end else if (u_checker.seen[tag]) begin
            // producer already broadcast, so the value sits in the register file.
            rdy_out  = 1'b1;
            data_out = u_checker.seen_data[tag];
        end else begin
            rdy_out  = 1'b0;
            data_out = data_in;
        end
    endtask

    task automatic drive_line(input int n);
        int b;
        b = n * REC_W;
        dispatch_valid = 1'b1;
        pc       = stim[b];
        opcode   = stim[b+1][6:0];
        funct3   = stim[b+2][2:0];
        src1_tag = stim[b+3][ooo_pkg::TAG_W-1:0];
        src2_tag = stim[b+6][ooo_pkg::TAG_W-1:0];
        drive_source(src1_tag, stim[b+4][0], stim[b+5], src1_ready, src1_data);
        drive_source(src2_tag, stim[b+7][0], stim[b+8], src2_ready, src2_data);
        imm      = stim[b+9];
        dest_tag = stim[b+10][ooo_pkg::TAG_W-1:0];
    endtask

    task automatic print_counts();
        $display("errors: value %0d, broadcast %0d, missing %0d, full %0d, setup %0d",
                 u_checker.value_errors, u_checker.bcast_errors,
                 u_checker.missing_errors, u_checker.fill_errors, setup_errors);
    endtask

    // run limit.
    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles with broadcasts still outstanding", cycle_count);
        print_counts();
        $display("Regression failed");
        $finish;
    end

    initial begin
        int total;
        rstn           = 1'b0;
        dispatch_valid = 1'b0;
        pc             = '0;
        opcode         = '0;
        funct3         = '0;
        src1_tag       = '0;
        src1_ready     = 1'b0;
        src1_data      = '0;
        src2_tag       = '0;
        src2_ready     = 1'b0;
        src2_data      = '0;
        imm            = '0;
        dest_tag       = '0;
        num_lines      = 0;
        num_expected   = 0;
        setup_errors   = 0;

        $readmemh("dv/ooo_stimulus.txt", stim);
        while (num_lines < MAX_LINES && !$isunknown(stim[num_lines*REC_W])) begin
            num_lines++;
        end
        cycle_limit = 40 * num_lines + 100;

        repeat (3) @(negedge clk);
        rstn = 1'b1;

        if (num_lines == 0) begin
            $display("no stimulus lines could be read from dv/ooo_stimulus.txt");
            setup_errors++;
        end
        for (int n = 0; n < num_lines; n++) begin
            if (stim[n*REC_W+12][0]) begin
                u_checker.add_expected(stim[n*REC_W+10][ooo_pkg::TAG_W-1:0],
                                       stim[n*REC_W+11]);
                num_expected++;
            end
        end

        // hold each line while the queue is full.
        for (int n = 0; n < num_lines; n++) begin
            @(negedge clk);
            drive_line(n);
            while (queue_full) begin
                @(negedge clk);
                drive_line(n);
            end
            if (stim[n*REC_W+12][0]) begin
                u_checker.note_dispatch();
            end
        end
        @(negedge clk);
        dispatch_valid = 1'b0;

        while (u_checker.seen_count < num_expected) begin
            @(negedge clk);
        end
        // room for a stray or repeated broadcast.
        repeat (20) @(negedge clk);

        u_checker.report_missing();
        u_checker.check_queue_filled();
        print_counts();
        total = u_checker.value_errors + u_checker.bcast_errors +
                u_checker.missing_errors + u_checker.fill_errors + setup_errors;
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- files.f
common/ooo_pkg.sv
hw/op_decoder.sv
issue_queue/issue_queue.sv
hw/alu_unit.sv
hw/cdb_arbiter.sv
hw/ooo_core_top.sv
dv/cdb_checker.sv
dv/tb_top.sv

//--- hw/alu_unit.sv
`timescale 1ns/1ns

module alu_unit (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        issue_valid,
    input  ooo_pkg::op_type_t           issue_op,
    input  logic [ooo_pkg::DATA_W-1:0]  issue_src1,
    input  logic [ooo_pkg::DATA_W-1:0]  issue_src2,
    input  logic [ooo_pkg::DATA_W-1:0]  issue_imm,
    input  logic [ooo_pkg::TAG_W-1:0]   issue_dest,
    input  logic                        cdb_ack,
    output logic                        alu_ready,
    output logic                        cdb_req,
    output logic [ooo_pkg::DATA_W-1:0]  result,
    output logic [ooo_pkg::TAG_W-1:0]   result_tag
);

    logic [ooo_pkg::DATA_W-1:0] alu_out;
    logic                       ack_wait;
    logic                       accept;

    always_comb begin
        case (issue_op)
            ooo_pkg::OP_ADD:  alu_out = issue_src1 + issue_src2;
            ooo_pkg::OP_XOR:  alu_out = issue_src1 ^ issue_src2;
            ooo_pkg::OP_ADDI: alu_out = issue_src1 + issue_imm;
            ooo_pkg::OP_ORI:  alu_out = issue_src1 | issue_imm;
            ooo_pkg::OP_SRAI: alu_out = $signed(issue_src1) >>> issue_imm[4:0];
            ooo_pkg::OP_LUI:  alu_out = issue_imm;
            default:          alu_out = '0;
        endcase
    end

    assign accept = issue_valid && alu_ready;

    // requester side of the req/ack handshake.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            alu_ready <= 1'b1;
            cdb_req   <= 1'b0;
            ack_wait  <= 1'b0;
        end else if (accept) begin
            alu_ready <= 1'b0;
            cdb_req   <= 1'b1;
        end else if (cdb_req && cdb_ack) begin
            // result went out this cycle.
            cdb_req  <= 1'b0;
            ack_wait <= 1'b1;
        end else if (ack_wait && !cdb_ack) begin
            ack_wait  <= 1'b0;
            alu_ready <= 1'b1;
        end
    end

    // held stable until the broadcast.
    always_ff @(posedge clk) begin
        if (accept) begin
            result     <= alu_out;
            result_tag <= issue_dest;
        end
    end

endmodule

//--- hw/cdb_arbiter.sv
`timescale 1ns/1ns

module cdb_arbiter #(
    parameter int NUM_ALUS = 3
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic [NUM_ALUS-1:0]                       cdb_req,
    input  logic [NUM_ALUS-1:0][ooo_pkg::DATA_W-1:0]  result,
    input  logic [NUM_ALUS-1:0][ooo_pkg::TAG_W-1:0]   result_tag,
    output logic [NUM_ALUS-1:0]                       cdb_ack,
    output logic                                      cdb_valid,
    output logic [ooo_pkg::TAG_W-1:0]                 cdb_tag,
    output logic [ooo_pkg::DATA_W-1:0]                cdb_data
);

    localparam int ALU_W = (NUM_ALUS > 1) ? $clog2(NUM_ALUS) : 1;

    logic [ALU_W-1:0] grant_idx;
    logic [ALU_W-1:0] last_idx;
    logic [ALU_W-1:0] next_idx;
    logic             next_found;
    logic             hold;

    // first requester after the last winner.
    always_comb begin
        int cand;
        next_found = 1'b0;
        next_idx   = '0;
        for (int k = NUM_ALUS; k >= 1; k--) begin
            cand = (int'(last_idx) + k) % NUM_ALUS;
            if (cdb_req[cand]) begin
                next_found = 1'b1;
                next_idx   = ALU_W'(cand);
            end
        end
    end

    // grant stays until its req falls.
    assign hold = (|cdb_ack) && cdb_req[grant_idx];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cdb_ack   <= '0;
            grant_idx <= '0;
            last_idx  <= ALU_W'(NUM_ALUS - 1);
        end else if (!hold) begin
            if (next_found) begin
                cdb_ack   <= NUM_ALUS'(1) << next_idx;
                grant_idx <= next_idx;
                last_idx  <= next_idx;
            end else begin
                cdb_ack <= '0;
            end
        end
    end

    assign cdb_valid = |(cdb_ack & cdb_req);
    assign cdb_tag   = result_tag[grant_idx];
    assign cdb_data  = result[grant_idx];

endmodule

//--- hw/ooo_core_top.sv
`timescale 1ns/1ns

module ooo_core_top #(
    parameter int QUEUE_DEPTH = 8,
    parameter int NUM_ALUS    = 3
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        dispatch_valid,
    input  logic [ooo_pkg::PC_W-1:0]    pc,
    input  logic [6:0]                  opcode,
    input  logic [2:0]                  funct3,
    input  logic [ooo_pkg::TAG_W-1:0]   src1_tag,
    input  logic                        src1_ready,
    input  logic [ooo_pkg::DATA_W-1:0]  src1_data,
    input  logic [ooo_pkg::TAG_W-1:0]   src2_tag,
    input  logic                        src2_ready,
    input  logic [ooo_pkg::DATA_W-1:0]  src2_data,
    input  logic [ooo_pkg::DATA_W-1:0]  imm,
    input  logic [ooo_pkg::TAG_W-1:0]   dest_tag,
    output logic                        queue_full,
    output logic                        cdb_valid,
    output logic [ooo_pkg::TAG_W-1:0]   cdb_tag,
    output logic [ooo_pkg::DATA_W-1:0]  cdb_data
);

    ooo_pkg::op_type_t                          op_type;
    logic                                       src1_unused;
    logic                                       src2_unused;
    logic [NUM_ALUS-1:0]                        alu_ready;
    logic [NUM_ALUS-1:0]                        issue_valid;
    ooo_pkg::op_type_t [NUM_ALUS-1:0]           issue_op;
    logic [NUM_ALUS-1:0][ooo_pkg::DATA_W-1:0]   issue_src1;
    logic [NUM_ALUS-1:0][ooo_pkg::DATA_W-1:0]   issue_src2;
    logic [NUM_ALUS-1:0][ooo_pkg::DATA_W-1:0]   issue_imm;
    logic [NUM_ALUS-1:0][ooo_pkg::TAG_W-1:0]    issue_dest;
    logic [NUM_ALUS-1:0]                        cdb_req;
    logic [NUM_ALUS-1:0]                        cdb_ack;
    logic [NUM_ALUS-1:0][ooo_pkg::DATA_W-1:0]   result;
    logic [NUM_ALUS-1:0][ooo_pkg::TAG_W-1:0]    result_tag;

    op_decoder u_decoder (
        .opcode      (opcode),
        .funct3      (funct3),
        .op_type     (op_type),
        .src1_unused (src1_unused),
        .src2_unused (src2_unused)
    );

    issue_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .NUM_ALUS    (NUM_ALUS)
    ) u_queue (
        .clk            (clk),
        .rstn           (rstn),
        .dispatch_valid (dispatch_valid),
        .op_type        (op_type),
        .src1_unused    (src1_unused),
        .src2_unused    (src2_unused),
        .pc             (pc),
        .src1_tag       (src1_tag),
        .src1_ready     (src1_ready),
        .src1_data      (src1_data),
        .src2_tag       (src2_tag),
        .src2_ready     (src2_ready),
        .src2_data      (src2_data),
        .imm            (imm),
        .dest_tag       (dest_tag),
        .alu_ready      (alu_ready),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data),
        .queue_full     (queue_full),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_src1     (issue_src1),
        .issue_src2     (issue_src2),
        .issue_imm      (issue_imm),
        .issue_dest     (issue_dest)
    );

    // one execution unit per issue port.
    for (genvar i = 0; i < NUM_ALUS; i++) begin : g_alu
        alu_unit u_alu (
            .clk         (clk),
            .rstn        (rstn),
            .issue_valid (issue_valid[i]),
            .issue_op    (issue_op[i]),
            .issue_src1  (issue_src1[i]),
            .issue_src2  (issue_src2[i]),
            .issue_imm   (issue_imm[i]),
            .issue_dest  (issue_dest[i]),
            .cdb_ack     (cdb_ack[i]),
            .alu_ready   (alu_ready[i]),
            .cdb_req     (cdb_req[i]),
            .result      (result[i]),
            .result_tag  (result_tag[i])
        );
    end

    cdb_arbiter #(
        .NUM_ALUS (NUM_ALUS)
    ) u_arbiter (
        .clk        (clk),
        .rstn       (rstn),
        .cdb_req    (cdb_req),
        .result     (result),
        .result_tag (result_tag),
        .cdb_ack    (cdb_ack),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_data   (cdb_data)
    );

endmodule

//--- hw/op_decoder.sv
`timescale 1ns/1ns

module op_decoder (
    input  logic [6:0]        opcode,
    input  logic [2:0]        funct3,
    output ooo_pkg::op_type_t op_type,
    output logic              src1_unused,
    output logic              src2_unused
);

    always_comb begin
        op_type = ooo_pkg::OP_NONE;
        case (opcode)
            ooo_pkg::OPC_RTYPE: begin
                case (funct3)
                    ooo_pkg::F3_ADD: op_type = ooo_pkg::OP_ADD;
                    ooo_pkg::F3_XOR: op_type = ooo_pkg::OP_XOR;
                    default:         op_type = ooo_pkg::OP_NONE;
                endcase
            end
            ooo_pkg::OPC_ITYPE: begin
                case (funct3)
                    ooo_pkg::F3_ADD:  op_type = ooo_pkg::OP_ADDI;
                    ooo_pkg::F3_SRAI: op_type = ooo_pkg::OP_SRAI;
                    ooo_pkg::F3_ORI:  op_type = ooo_pkg::OP_ORI;
                    default:          op_type = ooo_pkg::OP_NONE;
                endcase
            end
            ooo_pkg::OPC_LUI: op_type = ooo_pkg::OP_LUI;
            // no memory unit, so loads and stores never enter the queue.
            ooo_pkg::OPC_LOAD:  op_type = ooo_pkg::OP_NONE;
            ooo_pkg::OPC_STORE: op_type = ooo_pkg::OP_NONE;
            default:            op_type = ooo_pkg::OP_NONE;
        endcase
    end

    // lui reads no register; immediate ops read only src1.
    assign src1_unused = (op_type == ooo_pkg::OP_LUI);
    assign src2_unused = (op_type == ooo_pkg::OP_ADDI) ||
                         (op_type == ooo_pkg::OP_ORI)  ||
                         (op_type == ooo_pkg::OP_SRAI) ||
                         (op_type == ooo_pkg::OP_LUI);

endmodule

//--- issue_queue/issue_queue.sv
`timescale 1ns/1ns

module issue_queue #(
    parameter int QUEUE_DEPTH = 8,
    parameter int NUM_ALUS    = 3
) (
    input  logic                                           clk,
    input  logic                                           rstn,
    input  logic                                           dispatch_valid,
    input  ooo_pkg::op_type_t                              op_type,
    input  logic                                           src1_unused,
    input  logic                                           src2_unused,
    input  logic [ooo_pkg::PC_W-1:0]                       pc,
    input  logic [ooo_pkg::TAG_W-1:0]                      src1_tag,
    input  logic                                           src1_ready,
    input  logic [ooo_pkg::DATA_W-1:0]                     src1_data,
    input  logic [ooo_pkg::TAG_W-1:0]                      src2_tag,
    input  logic                                           src2_ready,
    input  logic [ooo_pkg::DATA_W-1:0]                     src2_data,
    input  logic [ooo_pkg::DATA_W-1:0]                     imm,
    input  logic [ooo_pkg::TAG_W-1:0]                      dest_tag,
    input  logic [NUM_ALUS-1:0]                            alu_ready,
    input  logic                                           cdb_valid,
    input  logic [ooo_pkg::TAG_W-1:0]                      cdb_tag,
    input  logic [ooo_pkg::DATA_W-1:0]                     cdb_data,
    output logic                                           queue_full,
    output logic [NUM_ALUS-1:0]                            issue_valid,
    output ooo_pkg::op_type_t [NUM_ALUS-1:0]               issue_op,
    output logic [NUM_ALUS-1:0][ooo_pkg::DATA_W-1:0]       issue_src1,
    output logic [NUM_ALUS-1:0][ooo_pkg::DATA_W-1:0]       issue_src2,
    output logic [NUM_ALUS-1:0][ooo_pkg::DATA_W-1:0]       issue_imm,
    output logic [NUM_ALUS-1:0][ooo_pkg::TAG_W-1:0]        issue_dest
);

    localparam int ALU_W = (NUM_ALUS > 1) ? $clog2(NUM_ALUS) : 1;
    localparam int IDX_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    // entry storage.
    logic [QUEUE_DEPTH-1:0]      valid;
    logic [QUEUE_DEPTH-1:0]      s1_rdy;
    logic [QUEUE_DEPTH-1:0]      s2_rdy;
    ooo_pkg::op_type_t           op_q    [QUEUE_DEPTH];
    logic [ooo_pkg::TAG_W-1:0]   s1_tag  [QUEUE_DEPTH];
    logic [ooo_pkg::TAG_W-1:0]   s2_tag  [QUEUE_DEPTH];
    logic [ooo_pkg::DATA_W-1:0]  s1_data [QUEUE_DEPTH];
    logic [ooo_pkg::DATA_W-1:0]  s2_data [QUEUE_DEPTH];
    logic [ooo_pkg::DATA_W-1:0]  imm_q   [QUEUE_DEPTH];
    logic [ooo_pkg::TAG_W-1:0]   dest_q  [QUEUE_DEPTH];
    logic [ALU_W-1:0]            alu_q   [QUEUE_DEPTH];

    logic [ALU_W-1:0]            alu_rr;
    logic                        alloc_found;
    logic [IDX_W-1:0]            alloc_idx;
    logic                        alloc_en;
    logic                        new_s1_rdy;
    logic                        new_s2_rdy;
    logic [ooo_pkg::DATA_W-1:0]  new_s1_data;
    logic [ooo_pkg::DATA_W-1:0]  new_s2_data;
    logic [NUM_ALUS-1:0]         sel_found;
    logic [NUM_ALUS-1:0][IDX_W-1:0] sel_idx;

    // lowest free entry.
    always_comb begin
        alloc_found = 1'b0;
        alloc_idx   = '0;
        for (int e = QUEUE_DEPTH - 1; e >= 0; e--) begin
            if (!valid[e]) begin
                alloc_found = 1'b1;
                alloc_idx   = IDX_W'(e);
            end
        end
    end

    assign queue_full = !alloc_found;
    assign alloc_en   = dispatch_valid && alloc_found && (op_type != ooo_pkg::OP_NONE);

    // source state at dispatch, including a broadcast in the same cycle.
    assign new_s1_rdy  = src1_unused || src1_ready || (cdb_valid && cdb_tag == src1_tag);
    assign new_s2_rdy  = src2_unused || src2_ready || (cdb_valid && cdb_tag == src2_tag);
    assign new_s1_data = src1_unused ? '0 : (src1_ready ? src1_data : cdb_data);
    assign new_s2_data = src2_unused ? '0 : (src2_ready ? src2_data : cdb_data);

    // per-alu pick of the lowest ready entry.
    // an alu that got an issue last cycle still shows ready, so skip it.
    always_comb begin
        for (int a = 0; a < NUM_ALUS; a++) begin
            sel_found[a] = 1'b0;
            sel_idx[a]   = '0;
            for (int e = QUEUE_DEPTH - 1; e >= 0; e--) begin
                if (alu_ready[a] && !issue_valid[a] && valid[e] && s1_rdy[e] &&
                    s2_rdy[e] && alu_q[e] == ALU_W'(a)) begin
                    sel_found[a] = 1'b1;
                    sel_idx[a]   = IDX_W'(e);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid       <= '0;
            alu_rr      <= '0;
            issue_valid <= '0;
        end else begin
            for (int a = 0; a < NUM_ALUS; a++) begin
                if (sel_found[a]) begin
                    valid[sel_idx[a]] <= 1'b0;
                end
            end
            if (alloc_en) begin
                valid[alloc_idx] <= 1'b1;
                alu_rr <= (alu_rr == ALU_W'(NUM_ALUS - 1)) ? '0 : alu_rr + 1'b1;
            end
            issue_valid <= sel_found;
        end
    end

    always_ff @(posedge clk) begin
        // wakeup of waiting sources.
        for (int e = 0; e < QUEUE_DEPTH; e++) begin
            if (valid[e] && !s1_rdy[e] && cdb_valid && cdb_tag == s1_tag[e]) begin
                s1_rdy[e]  <= 1'b1;
                s1_data[e] <= cdb_data;
            end
            if (valid[e] && !s2_rdy[e] && cdb_valid && cdb_tag == s2_tag[e]) begin
                s2_rdy[e]  <= 1'b1;
                s2_data[e] <= cdb_data;
            end
        end
        if (alloc_en) begin
            op_q[alloc_idx]    <= op_type;
            s1_tag[alloc_idx]  <= src1_tag;
            s2_tag[alloc_idx]  <= src2_tag;
            s1_rdy[alloc_idx]  <= new_s1_rdy;
            s2_rdy[alloc_idx]  <= new_s2_rdy;
            s1_data[alloc_idx] <= new_s1_data;
            s2_data[alloc_idx] <= new_s2_data;
            imm_q[alloc_idx]   <= imm;
            dest_q[alloc_idx]  <= dest_tag;
            alu_q[alloc_idx]   <= alu_rr;
        end
        for (int a = 0; a < NUM_ALUS; a++) begin
            if (sel_found[a]) begin
                issue_op[a]   <= op_q[sel_idx[a]];
                issue_src1[a] <= s1_data[sel_idx[a]];
                issue_src2[a] <= s2_data[sel_idx[a]];
                issue_imm[a]  <= imm_q[sel_idx[a]];
                issue_dest[a] <= dest_q[sel_idx[a]];
            end
        end
    end

endmodule
